/* hdl/jtgng_video_pkg.sv */
`default_nettype none

package jtgng_video_pkg;

	// Native raster scaled down for simulation
	localparam int H_ACTIVE    = 16;
	localparam int H_TOTAL     = 24;
	localparam int V_ACTIVE    = 8;
	localparam int V_TOTAL     = 12;

	// VGA sync placement
	localparam int V_SYNC_LINE = 10;  // Native line with vs high
	localparam int HS_START    = 18;  // First hs slot of each replay
	localparam int HS_LEN      = 3;

	// Counter and line buffer address widths
	localparam int HCNT_W  = $clog2(H_TOTAL);
	localparam int VCNT_W  = $clog2(V_TOTAL);
	localparam int HADDR_W = $clog2(H_ACTIVE);

	// Colour depth
	localparam int COLOR_W = 4;
	localparam int VGA_W   = 6;

	localparam int RST_STRETCH = 3;  // Extra reset cycles

	typedef enum logic [1:0] {
		ST_RESET,
		ST_WAIT_FRAME,
		ST_RUN
	} ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/jtgng_video_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface video_if import jtgng_video_pkg::*; ();

	logic                pxl_cen;  // Native pixel enable
	logic [HCNT_W-1:0]   hcnt;
	logic [VCNT_W-1:0]   vcnt;
	logic                lhbl;     // High while inside the visible columns
	logic                lvbl;     // High while inside the visible lines
	logic [COLOR_W-1:0]  red;
	logic [COLOR_W-1:0]  green;
	logic [COLOR_W-1:0]  blue;

	// Raster generator
	modport timing_mp(output pxl_cen, hcnt, vcnt, lhbl, lvbl);

	// Pixel source
	modport pattern_mp(
		input  pxl_cen, hcnt, vcnt, lhbl, lvbl,
		output red, green, blue
	);

	// Scan doubler side
	modport sink_mp(input pxl_cen, hcnt, vcnt, lhbl, lvbl, red, green, blue);

endinterface

`default_nettype wire

/* hdl/jtgng_video_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_video_ctrl import jtgng_video_pkg::*; (
	input  logic clk_gng,
	input  logic rst,
	input  logic frame_start,
	input  logic dip_flip,
	input  logic dip_test,
	output logic core_rst,
	output logic dip_flip_q,
	output logic dip_test_q
);

	logic [RST_STRETCH-1:0] rst_sr;
	ctrl_state_t            state;

	// Reset stretcher shifts ones out after rst is released
	always_ff @(posedge clk_gng) begin
		if (rst) begin
			{core_rst, rst_sr} <= '1;
		end else begin
			{core_rst, rst_sr} <= {rst_sr, 1'b0};
		end
	end

	always_ff @(posedge clk_gng) begin
		if (core_rst) begin
			state      <= ST_RESET;
			dip_flip_q <= 1'b0;
			dip_test_q <= 1'b0;
		end else begin
			case (state)
				ST_RESET:      state <= ST_WAIT_FRAME;
				ST_WAIT_FRAME: if (frame_start) state <= ST_RUN;  // First full frame
				ST_RUN:        state <= ST_RUN;
				default:       state <= ST_RESET;
			endcase
			// DIPs only change at a frame boundary
			if (state != ST_RESET && frame_start) begin
				dip_flip_q <= dip_flip;
				dip_test_q <= dip_test;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/jtgng_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_timing import jtgng_video_pkg::*; (
	input  logic         clk_gng,
	input  logic         core_rst,
	video_if.timing_mp   vid,
	output logic         frame_start
);

	logic h_last;
	logic v_last;

	assign h_last = vid.hcnt == HCNT_W'(H_TOTAL - 1);
	assign v_last = vid.vcnt == VCNT_W'(V_TOTAL - 1);

	// Pixel enable at half the clock rate steps the counters
	always_ff @(posedge clk_gng) begin
		if (core_rst) begin
			vid.pxl_cen <= 1'b0;
			vid.hcnt    <= '0;
			vid.vcnt    <= '0;
		end else begin
			vid.pxl_cen <= ~vid.pxl_cen;
			if (vid.pxl_cen) begin
				if (h_last) begin
					vid.hcnt <= '0;
					if (v_last) begin
						vid.vcnt <= '0;
					end else begin
						vid.vcnt <= vid.vcnt + 1'b1;
					end
				end else begin
					vid.hcnt <= vid.hcnt + 1'b1;
				end
			end
		end
	end

	// Blanking straight from the counts
	assign vid.lhbl = vid.hcnt < HCNT_W'(H_ACTIVE);
	assign vid.lvbl = vid.vcnt < VCNT_W'(V_ACTIVE);

	// Last enable of pixel (0,0)
	assign frame_start = vid.pxl_cen && vid.hcnt == '0 && vid.vcnt == '0;

endmodule

`default_nettype wire

/* hdl/jtgng_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_pattern import jtgng_video_pkg::*; (
	input  logic         clk_gng,
	input  logic         core_rst,
	video_if.pattern_mp  vid,
	input  logic         dip_flip_q,
	input  logic         dip_test_q
);

	logic [HCNT_W-1:0]  hcnt_q;
	logic [VCNT_W-1:0]  vcnt_q;
	logic               active_q;
	logic               cen_d;
	logic [HCNT_W-1:0]  x;
	logic [COLOR_W-1:0] sum;

	assign x   = dip_flip_q ? HCNT_W'(H_ACTIVE - 1) - hcnt_q : hcnt_q;  // Mirrored column
	assign sum = x[COLOR_W-1:0] + COLOR_W'(vcnt_q);

	always_ff @(posedge clk_gng) begin
		if (core_rst) begin
			cen_d <= 1'b0;
		end else begin
			cen_d <= vid.pxl_cen;
		end
	end

	// Coordinates of the pixel that ends on this enable
	always_ff @(posedge clk_gng) begin
		if (vid.pxl_cen) begin
			hcnt_q   <= vid.hcnt;
			vcnt_q   <= vid.vcnt;
			active_q <= vid.lhbl && vid.lvbl;
		end
	end

	// Colour one cycle later so a fresh DIP latch is seen
	always_ff @(posedge clk_gng) begin
		if (cen_d) begin
			if (!active_q) begin
				vid.red   <= '0;
				vid.green <= '0;
				vid.blue  <= '0;
			end else if (dip_test_q) begin
				vid.red   <= x[0] ? '0 : '1;  // Vertical bars
				vid.green <= x[0] ? '0 : '1;
				vid.blue  <= x[0] ? '0 : '1;
			end else begin
				vid.red   <= x[COLOR_W-1:0];
				vid.green <= COLOR_W'(vcnt_q);
				vid.blue  <= sum;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/jtgng_scandoubler.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_scandoubler import jtgng_video_pkg::*; (
	input  logic             clk_gng,
	input  logic             core_rst,
	video_if.sink_mp         vid,
	output logic [VGA_W-1:0] vga_r,
	output logic [VGA_W-1:0] vga_g,
	output logic [VGA_W-1:0] vga_b,
	output logic             vga_hs,
	output logic             vga_vs,
	output logic             vga_de
);

	logic [3*COLOR_W-1:0] line_buf [2*H_ACTIVE];  // Ping-pong pair of lines
	logic [HADDR_W-1:0]   wr_addr;
	logic                 wr_sel;
	logic                 wr_en;
	logic [HCNT_W-1:0]    rd_slot;
	logic                 line_act;
	logic                 line_end;
	logic                 de;
	logic                 hs;
	logic [3*COLOR_W-1:0] rd_pix;

	// 4 to 6 bits by repeating the top bits
	function automatic logic [VGA_W-1:0] expand(input logic [COLOR_W-1:0] c);
		return {c, c[COLOR_W-1 -: VGA_W-COLOR_W]};
	endfunction

	assign line_end = vid.pxl_cen && vid.hcnt == HCNT_W'(H_TOTAL - 1);

	// Colour arrives one pixel after its coordinates
	always_ff @(posedge clk_gng) begin
		if (core_rst) begin
			wr_en <= 1'b0;
		end else if (vid.pxl_cen) begin
			wr_en <= vid.lhbl && vid.lvbl;
		end
	end

	always_ff @(posedge clk_gng) begin
		if (vid.pxl_cen) begin
			wr_addr <= vid.hcnt[HADDR_W-1:0];
			wr_sel  <= vid.vcnt[0];  // Buffer half by line parity
		end
	end

	always_ff @(posedge clk_gng) begin
		if (vid.pxl_cen && wr_en) begin
			line_buf[{wr_sel, wr_addr}] <= {vid.red, vid.green, vid.blue};
		end
	end

	// Read slot runs at full rate for two replays per native line
	always_ff @(posedge clk_gng) begin
		if (core_rst) begin
			rd_slot  <= '0;
			line_act <= 1'b0;
		end else begin
			if (line_end || rd_slot == HCNT_W'(H_TOTAL - 1)) begin
				rd_slot <= '0;
			end else begin
				rd_slot <= rd_slot + 1'b1;
			end
			if (line_end) begin
				line_act <= vid.lvbl;  // Was the finished line visible
			end
		end
	end

	assign de     = line_act && rd_slot < HCNT_W'(H_ACTIVE);
	assign hs     = rd_slot >= HCNT_W'(HS_START) && rd_slot < HCNT_W'(HS_START + HS_LEN);
	assign rd_pix = line_buf[{~vid.vcnt[0], rd_slot[HADDR_W-1:0]}];  // Previous line

	always_ff @(posedge clk_gng) begin
		if (core_rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_de <= 1'b0;
		end else begin
			vga_de <= de;
			vga_hs <= hs;
			vga_vs <= vid.vcnt == VCNT_W'(V_SYNC_LINE);
			vga_r  <= de ? expand(rd_pix[3*COLOR_W-1 -: COLOR_W]) : '0;
			vga_g  <= de ? expand(rd_pix[2*COLOR_W-1 -: COLOR_W]) : '0;
			vga_b  <= de ? expand(rd_pix[COLOR_W-1:0]) : '0;
		end
	end

endmodule

`default_nettype wire

/* hdl/jtgng_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_video_top import jtgng_video_pkg::*; (
	input  logic             clk_gng,
	input  logic             rst,
	input  logic             dip_flip,
	input  logic             dip_test,
	output logic [VGA_W-1:0] vga_r,
	output logic [VGA_W-1:0] vga_g,
	output logic [VGA_W-1:0] vga_b,
	output logic             vga_hs,
	output logic             vga_vs,
	output logic             vga_de
);

	logic core_rst;
	logic dip_flip_q;
	logic dip_test_q;
	logic frame_start;

	video_if vid();

	jtgng_video_ctrl u_ctrl (
		.clk_gng     ( clk_gng     ),
		.rst         ( rst         ),
		.frame_start ( frame_start ),
		.dip_flip    ( dip_flip    ),
		.dip_test    ( dip_test    ),
		.core_rst    ( core_rst    ),
		.dip_flip_q  ( dip_flip_q  ),
		.dip_test_q  ( dip_test_q  )
	);

	jtgng_timing u_timing (
		.clk_gng     ( clk_gng     ),
		.core_rst    ( core_rst    ),
		.vid         ( vid         ),
		.frame_start ( frame_start )
	);

	jtgng_pattern u_pattern (
		.clk_gng     ( clk_gng     ),
		.core_rst    ( core_rst    ),
		.vid         ( vid         ),
		.dip_flip_q  ( dip_flip_q  ),
		.dip_test_q  ( dip_test_q  )
	);

	// Native to VGA rate
	jtgng_scandoubler u_scan (
		.clk_gng     ( clk_gng     ),
		.core_rst    ( core_rst    ),
		.vid         ( vid         ),
		.vga_r       ( vga_r       ),
		.vga_g       ( vga_g       ),
		.vga_b       ( vga_b       ),
		.vga_hs      ( vga_hs      ),
		.vga_vs      ( vga_vs      ),
		.vga_de      ( vga_de      )
	);

endmodule

`default_nettype wire

/* tests/jtgng_video_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_video_properties import jtgng_video_pkg::*; (
	input  logic             clk_gng,
	input  logic             rst,
	input  logic [VGA_W-1:0] vga_r,
	input  logic [VGA_W-1:0] vga_g,
	input  logic [VGA_W-1:0] vga_b,
	input  logic             vga_hs,
	input  logic             vga_vs,
	input  logic             vga_de
);

	int unsigned hs_run;           // Cycles of the current hs pulse
	int unsigned de_vs_fails = 0;
	int unsigned blank_fails = 0;
	int unsigned hs_len_fails = 0;

	always_ff @(posedge clk_gng) begin
		if (rst || !vga_hs) begin
			hs_run <= 0;
		end else begin
			hs_run <= hs_run + 1;
		end
	end

	// Vertical sync sits in the blanking area
	de_vs_apart: assert property (@(posedge clk_gng) disable iff (rst) !(vga_de && vga_vs))
		else begin
			de_vs_fails++;
			$error("vga_de and vga_vs high in the same cycle");
		end

	blank_black: assert property (@(posedge clk_gng) disable iff (rst)
		!vga_de |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else begin
			blank_fails++;
			$error("Colour not black while vga_de is low");
		end

	hs_width: assert property (@(posedge clk_gng) disable iff (rst)
		$fell(vga_hs) |-> hs_run == HS_LEN)
		else begin
			hs_len_fails++;
			$error("vga_hs pulse of %0d cycles", hs_run);
		end

endmodule

bind jtgng_video_top jtgng_video_properties u_props (.*);

`default_nettype wire

/* tests/jtgng_video_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module jtgng_video_tb import jtgng_video_pkg::*; ();

	localparam int FRAME_CYCLES   = 2 * H_TOTAL * V_TOTAL;
	localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 100;

	logic               clk_gng;
	logic               rst;
	logic               dip_flip;
	logic               dip_test;
	logic [VGA_W-1:0]   vga_r;
	logic [VGA_W-1:0]   vga_g;
	logic [VGA_W-1:0]   vga_b;
	logic               vga_hs;
	logic               vga_vs;
	logic               vga_de;

	// Reference model state owned by the monitor
	logic               armed = 1'b0;
	logic               mode_flip = 1'b0;
	logic               mode_test = 1'b0;
	logic               prev_vs = 1'b0;
	logic               prev_hs = 1'b0;
	logic               prev_de = 1'b0;
	logic [3*VGA_W-1:0] exp_rgb;
	int                 de_lines = 0;
	int                 col = 0;
	int                 hs_pulses = 0;
	int                 vs_len = 0;
	int                 frames_checked = 0;
	int                 pix_errs = 0;
	int                 frame_errs = 0;
	int                 rst_errs = 0;

	jtgng_video_top UUT (
		.clk_gng  ( clk_gng  ),
		.rst      ( rst      ),
		.dip_flip ( dip_flip ),
		.dip_test ( dip_test ),
		.vga_r    ( vga_r    ),
		.vga_g    ( vga_g    ),
		.vga_b    ( vga_b    ),
		.vga_hs   ( vga_hs   ),
		.vga_vs   ( vga_vs   ),
		.vga_de   ( vga_de   )
	);

	// Top two bits repeated below the 4-bit value
	function automatic logic [VGA_W-1:0] widen(input logic [COLOR_W-1:0] c);
		return (VGA_W'(c) << (VGA_W - COLOR_W)) | VGA_W'(c >> (2 * COLOR_W - VGA_W));
	endfunction

	function automatic logic [3*VGA_W-1:0] expected_rgb(input int line, input int c,
			input logic flip, input logic test);
		int                 x;
		int                 y;
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
		x = flip ? H_ACTIVE - 1 - c : c;
		y = line / 2;  // Each source line shown twice
		if (test) begin
			r = (x % 2 == 0) ? 4'hf : 4'h0;
			g = r;
			b = r;
		end else begin
			r = COLOR_W'(x);
			g = COLOR_W'(y);
			b = COLOR_W'(x + y);
		end
		return {widen(r), widen(g), widen(b)};
	endfunction

	initial begin
		clk_gng = 1'b0;
		forever #10 clk_gng = ~clk_gng;
	end

	// New DIP values while vs is high take effect in the next frame
	initial begin
		logic [31:0] rnd;
		dip_flip = 1'b0;
		dip_test = 1'b0;
		void'($urandom(32'h9841_a84b));
		forever begin
			@(posedge vga_vs);
			#2;
			rnd = $urandom;
			dip_flip = rnd[0];
			dip_test = rnd[1];
			// Inputs flip inside the picture, the shown mode must not
			@(posedge vga_de);
			#2;
			dip_flip = ~rnd[0];
			dip_test = ~rnd[1];
		end
	end

	always @(negedge clk_gng) begin
		if (rst) begin
			armed   = 1'b0;
			prev_vs = 1'b0;
			prev_hs = 1'b0;
			prev_de = 1'b0;
			vs_len  = 0;
		end else begin
			if (prev_vs && !vga_vs) begin  // End of vertical sync
				if (vs_len != 2 * H_TOTAL) begin
					$display("ERROR at %0t: vga_vs high for %0d cycles, expected %0d",
						$time, vs_len, 2 * H_TOTAL);
					frame_errs++;
				end
				vs_len = 0;
				if (armed) begin
					if (de_lines != 2 * V_ACTIVE) begin
						$display("ERROR at %0t: frame had %0d active lines, expected %0d",
							$time, de_lines, 2 * V_ACTIVE);
						frame_errs++;
					end
					if (hs_pulses != 2 * V_TOTAL) begin
						$display("ERROR at %0t: frame had %0d hs pulses, expected %0d",
							$time, hs_pulses, 2 * V_TOTAL);
						frame_errs++;
					end
					frames_checked++;
				end
				armed     = 1'b1;
				mode_flip = dip_flip;
				mode_test = dip_test;
				de_lines  = 0;
				col       = 0;
				hs_pulses = 0;
			end
			if (vga_vs) vs_len++;
			if (armed && vga_hs && !prev_hs) hs_pulses++;
			if (armed && vga_de) begin
				if (col < H_ACTIVE) begin
					exp_rgb = expected_rgb(de_lines, col, mode_flip, mode_test);
					if (vga_r != exp_rgb[3*VGA_W-1 -: VGA_W]) begin
						$display("MISMATCH t=%0t vga_r got %h expected %h (line %0d col %0d)",
							$time, vga_r, exp_rgb[3*VGA_W-1 -: VGA_W], de_lines, col);
						pix_errs++;
					end
					if (vga_g != exp_rgb[2*VGA_W-1 -: VGA_W]) begin
						$display("MISMATCH t=%0t vga_g got %h expected %h (line %0d col %0d)",
							$time, vga_g, exp_rgb[2*VGA_W-1 -: VGA_W], de_lines, col);
						pix_errs++;
					end
					if (vga_b != exp_rgb[VGA_W-1:0]) begin
						$display("MISMATCH t=%0t vga_b got %h expected %h (line %0d col %0d)",
							$time, vga_b, exp_rgb[VGA_W-1:0], de_lines, col);
						pix_errs++;
					end
				end
				col++;
			end else if (armed && prev_de) begin
				if (col != H_ACTIVE) begin
					$display("ERROR at %0t: active line %0d lasted %0d cycles, expected %0d",
						$time, de_lines, col, H_ACTIVE);
					frame_errs++;
				end
				de_lines++;
				col = 0;
			end
			prev_vs = vga_vs;
			prev_hs = vga_hs;
			prev_de = vga_de;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_gng);
			cycles++;
		end
		$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int unsigned assert_errs;
		rst = 1'b1;
		repeat (2) @(posedge clk_gng);
		#2 rst = 1'b0;
		while (frames_checked < 7) @(posedge clk_gng);
		@(posedge vga_de);  // Reset again in the middle of a visible line
		repeat (4) @(posedge clk_gng);
		#2 rst = 1'b1;
		repeat (2) @(posedge clk_gng);
		#2 rst = 1'b0;
		repeat (RST_STRETCH) @(posedge clk_gng);
		@(negedge clk_gng);
		if ({vga_r, vga_g, vga_b, vga_hs, vga_vs, vga_de} != '0) begin
			$display("MISMATCH t=%0t {vga_r,vga_g,vga_b,vga_hs,vga_vs,vga_de} got %h expected 0",
				$time, {vga_r, vga_g, vga_b, vga_hs, vga_vs, vga_de});
			rst_errs++;
		end
		while (frames_checked < 12) @(posedge clk_gng);
		assert_errs = UUT.u_props.de_vs_fails + UUT.u_props.blank_fails
			+ UUT.u_props.hs_len_fails;
		$display("Errors: pixel %0d, frame %0d, reset %0d, assertion %0d in %0d frames",
			pix_errs, frame_errs, rst_errs, assert_errs, frames_checked);
		if (pix_errs + frame_errs + rst_errs + assert_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/jtgng_video_pkg.sv
hdl/jtgng_video_if.sv
hdl/jtgng_video_ctrl.sv
hdl/jtgng_timing.sv
hdl/jtgng_pattern.sv
hdl/jtgng_scandoubler.sv
hdl/jtgng_video_top.sv
tests/jtgng_video_properties.sv
tests/jtgng_video_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the video path simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module jtgng_video_tb \
	--Mdir obj_dir -o jtgng_video_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/jtgng_video_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
exit 0
